// File: Makefile
# Verilator build and run of the cache data array testbench

VERILATOR ?= verilator
TOP       ?= cachemem_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the case file path is relative to this directory
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/cache_defs.svh
// geometry is fixed at 32 lines of 64 bits, 4-way; the LRU tree assumes a power-of-two way count
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// associativity
`define NUM_WAYS 4

// 32 lines spread over the ways
`define NUM_SETS 8

// set index width, log2 of NUM_SETS
`define SET_BITS 3

// 13-bit line address minus the index
`define TAG_BITS 10

// payload width of one line
`define DATA_BITS 64

// tree nodes per set, one less than the ways
`define LRU_BITS 3

`endif

// File: design/cache_pkg.sv
// line and way types sized from cache_defs.svh; line layout is data, tag, valid, dirty from the top
`include "cache_defs.svh"

package cache_pkg;

  // one stored line of 76 packed bits
  typedef struct packed {
    logic [`DATA_BITS-1:0] data;
    logic [`TAG_BITS-1:0]  tag;
    logic                  valid;
    logic                  dirty;
  } cache_line_t;

  // way number within a set
  typedef logic [$clog2(`NUM_WAYS)-1:0] way_t;

endpackage

// File: design/cachemem.sv
// 32x64 4-way data array; same-cycle output levels, no handshake, write ports never share a set
`timescale 1ns/1ps
`include "cache_defs.svh"

module cachemem import cache_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,

  input  logic                  rd_en,
  input  logic [`SET_BITS-1:0]  rd_idx,
  input  logic [`TAG_BITS-1:0]  rd_tag,

  input  logic                  wr_en_0,
  input  logic [`SET_BITS-1:0]  wr_idx_0,
  input  logic [`TAG_BITS-1:0]  wr_tag_0,
  input  logic [`DATA_BITS-1:0] wr_data_0,
  input  logic                  wr_dirty_0,

  input  logic                  wr_en_1,
  input  logic [`SET_BITS-1:0]  wr_idx_1,
  input  logic [`TAG_BITS-1:0]  wr_tag_1,
  input  logic [`DATA_BITS-1:0] wr_data_1,
  input  logic                  wr_dirty_1,

  output logic [`DATA_BITS-1:0] rd_data,
  output logic                  rd_valid,
  output logic                  rd_miss_valid,
  output logic [`SET_BITS-1:0]  rd_miss_idx,
  output logic [`TAG_BITS-1:0]  rd_miss_tag,

  output logic                  wr_miss_valid_0,
  output logic [`SET_BITS-1:0]  wr_miss_idx_0,
  output logic [`TAG_BITS-1:0]  wr_miss_tag_0,
  output logic                  wr_miss_valid_1,
  output logic [`SET_BITS-1:0]  wr_miss_idx_1,
  output logic [`TAG_BITS-1:0]  wr_miss_tag_1,

  output logic                  victim_valid_0,
  output logic [`SET_BITS-1:0]  victim_idx_0,
  output cache_line_t           victim_0,
  output logic                  victim_valid_1,
  output logic [`SET_BITS-1:0]  victim_idx_1,
  output cache_line_t           victim_1
);

  localparam int WR_PORTS = 2;

  // storage
  cache_line_t [`NUM_WAYS-1:0] lines [`NUM_SETS];
  logic [`LRU_BITS-1:0]        lru   [`NUM_SETS];

  // write ports gathered into arrays
  logic                  wr_en   [WR_PORTS];
  logic [`SET_BITS-1:0]  wr_idx  [WR_PORTS];
  logic [`TAG_BITS-1:0]  wr_tag  [WR_PORTS];
  logic [`DATA_BITS-1:0] wr_data [WR_PORTS];
  logic                  wr_dirty[WR_PORTS];

  logic                  wr_hit       [WR_PORTS];
  way_t                  wr_hit_way   [WR_PORTS];
  way_t                  wr_victim_way[WR_PORTS];
  way_t                  wr_way       [WR_PORTS];
  logic                  wr_miss      [WR_PORTS];
  logic [`LRU_BITS-1:0]  wr_lru_in    [WR_PORTS];
  logic [`LRU_BITS-1:0]  wr_lru_next  [WR_PORTS];
  cache_line_t           victim_line  [WR_PORTS];
  logic                  fwd          [WR_PORTS];

  logic                  rd_hit;
  way_t                  rd_way;
  logic [`LRU_BITS-1:0]  rd_lru_in;
  logic [`LRU_BITS-1:0]  rd_lru_next;

  assign wr_en[0]    = wr_en_0;
  assign wr_idx[0]   = wr_idx_0;
  assign wr_tag[0]   = wr_tag_0;
  assign wr_data[0]  = wr_data_0;
  assign wr_dirty[0] = wr_dirty_0;
  assign wr_en[1]    = wr_en_1;
  assign wr_idx[1]   = wr_idx_1;
  assign wr_tag[1]   = wr_tag_1;
  assign wr_data[1]  = wr_data_1;
  assign wr_dirty[1] = wr_dirty_1;

  // LRU chain order is write 0, write 1, read
  assign wr_lru_in[0] = lru[wr_idx[0]];
  assign wr_lru_in[1] = (wr_idx[1] == wr_idx[0]) ? wr_lru_next[0] : lru[wr_idx[1]];
  assign rd_lru_in    = (rd_idx == wr_idx[1]) ? wr_lru_next[1] :
                        (rd_idx == wr_idx[0]) ? wr_lru_next[0] : lru[rd_idx];

  for (genvar p = 0; p < WR_PORTS; p++) begin : g_wr
    way_lookup wr_lookup_inst (
      .tag   (wr_tag[p]),
      .lines (lines[wr_idx[p]]),
      .hit   (wr_hit[p]),
      .way   (wr_hit_way[p])
    );

    plru_tree wr_plru_inst (
      .bits       (wr_lru_in[p]),
      .access_way (wr_way[p]),
      .access     (wr_en[p]),
      .bits_next  (wr_lru_next[p]),
      .victim_way (wr_victim_way[p])
    );

    // hit rewrites in place, miss fills the LRU way
    assign wr_way[p]      = wr_hit[p] ? wr_hit_way[p] : wr_victim_way[p];
    assign wr_miss[p]     = wr_en[p] & ~wr_hit[p];
    assign victim_line[p] = lines[wr_idx[p]][wr_victim_way[p]];

    assign fwd[p] = rd_en & wr_en[p] & (wr_idx[p] == rd_idx) & (wr_tag[p] == rd_tag);
  end

  way_lookup rd_lookup_inst (
    .tag   (rd_tag),
    .lines (lines[rd_idx]),
    .hit   (rd_hit),
    .way   (rd_way)
  );

  // read victim choice has no consumer
  plru_tree rd_plru_inst (
    .bits       (rd_lru_in),
    .access_way (rd_way),
    .access     (rd_en & rd_hit),
    .bits_next  (rd_lru_next),
    .victim_way ()
  );

  // port 1 forwarding wins over port 0 on the read side
  assign rd_data       = fwd[1] ? wr_data[1] :
                         fwd[0] ? wr_data[0] : lines[rd_idx][rd_way].data;
  assign rd_valid      = rd_en & (fwd[0] | fwd[1] | rd_hit);
  assign rd_miss_valid = rd_en & ~rd_valid;
  assign rd_miss_idx   = rd_idx;
  assign rd_miss_tag   = rd_tag;

  // write miss and victim strobes
  assign wr_miss_valid_0 = wr_miss[0];
  assign wr_miss_idx_0   = wr_idx[0];
  assign wr_miss_tag_0   = wr_tag[0];
  assign wr_miss_valid_1 = wr_miss[1];
  assign wr_miss_idx_1   = wr_idx[1];
  assign wr_miss_tag_1   = wr_tag[1];

  assign victim_valid_0 = wr_miss[0] & victim_line[0].valid;
  assign victim_idx_0   = wr_idx[0];
  assign victim_0       = victim_line[0];
  assign victim_valid_1 = wr_miss[1] & victim_line[1].valid;
  assign victim_idx_1   = wr_idx[1];
  assign victim_1       = victim_line[1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `NUM_SETS; s++) begin
        lru[s] <= '0;
        for (int w = 0; w < `NUM_WAYS; w++) begin
          lines[s][w].valid <= 1'b0;
        end
      end
    end else begin
      for (int p = 0; p < WR_PORTS; p++) begin
        if (wr_en[p]) begin
          lines[wr_idx[p]][wr_way[p]] <= '{data:  wr_data[p],
                                           tag:   wr_tag[p],
                                           valid: 1'b1,
                                           dirty: wr_dirty[p]};
          lru[wr_idx[p]] <= wr_lru_next[p];
        end
      end
      // last in the chain, so it carries earlier updates to the same set
      if (rd_en) begin
        lru[rd_idx] <= rd_lru_next;
      end
    end
  end

  a_wr_sets_distinct: assert property (@(posedge clock) disable iff (reset)
    (wr_en_0 && wr_en_1) |-> (wr_idx_0 != wr_idx_1))
    else $error("cachemem: both write ports hit set %0d", wr_idx_0);

  // an evicted line still holding the written tag means the lookup missed a live line
  a_victim_tag_differs: assert property (@(posedge clock) disable iff (reset)
    (!victim_valid_0 || victim_0.tag != wr_tag_0) &&
    (!victim_valid_1 || victim_1.tag != wr_tag_1))
    else $error("cachemem: victim line carries the tag being written");

endmodule

// File: design/plru_tree.sv
// tree pseudo-LRU for one set, node 0 is the root and node n has children 2n+1 and 2n+2
`timescale 1ns/1ps
`include "cache_defs.svh"

module plru_tree import cache_pkg::*; (
  input  logic [`LRU_BITS-1:0] bits,
  input  way_t                 access_way,
  input  logic                 access,
  output logic [`LRU_BITS-1:0] bits_next,
  output way_t                 victim_way
);

  localparam int LEVELS = $clog2(`NUM_WAYS);

  // walk from the root following the node bits
  // 0 goes left, 1 goes right, way number built msb first
  always_comb begin
    int node;
    logic dir;
    node = 0;
    dir = 1'b0;
    victim_way = '0;
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      dir = bits[node];
      victim_way[LEVELS-1-lvl] = dir;
      node = 2 * node + 1 + int'(dir);
    end
  end

  // point every node on the accessed path away from it
  always_comb begin
    int node;
    logic dir;
    node = 0;
    dir = 1'b0;
    bits_next = bits;
    if (access) begin
      for (int lvl = 0; lvl < LEVELS; lvl++) begin
        dir = access_way[LEVELS-1-lvl];
        // went left so the node now prefers the right half
        bits_next[node] = ~dir;
        node = 2 * node + 1 + int'(dir);
      end
    end
  end

endmodule

// File: design/way_lookup.sv
// purely combinational tag compare over one set; way is only meaningful while hit is high
`timescale 1ns/1ps
`include "cache_defs.svh"

module way_lookup import cache_pkg::*; (
  input  logic [`TAG_BITS-1:0]               tag,
  input  cache_line_t [`NUM_WAYS-1:0]        lines,
  output logic                               hit,
  output way_t                               way
);

  logic [`NUM_WAYS-1:0] match;

  // valid line with equal tag
  always_comb begin
    for (int i = 0; i < `NUM_WAYS; i++) begin
      match[i] = lines[i].valid && (lines[i].tag == tag);
    end
  end

  assign hit = |match;

  // one-hot to binary, lowest way wins if ever more than one
  always_comb begin
    way = '0;
    for (int i = `NUM_WAYS - 1; i >= 0; i--) begin
      if (match[i]) begin
        way = way_t'(i);
      end
    end
  end

  // a tag lives in at most one way of a set, which the fill and hit logic upstream must keep
  always_comb begin
    a_single_hit: assert final ($onehot0(match))
      else $error("way_lookup: tag %h hits more than one way", tag);
  end

endmodule

// File: tb/cachemem_cases.txt
// per cycle: rd en idx tag, wr0 en idx tag data dirty, wr1 en idx tag data dirty, then expected
// rd_valid rd_data rd_miss, wr_miss 0 1, victim_valid 0 1, victim tag data dirty
// reads after reset miss
1 0 005  0 0 000 0 0  0 0 000 0 0  0 0 1  0 0  0 0 000 0 0
1 7 3ff  0 0 000 0 0  0 0 000 0 0  0 0 1  0 0  0 0 000 0 0
// fill of an empty set, then read back
0 0 000  1 1 011 1111 0  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
1 1 011  0 0 000 0 0  0 0 000 0 0  1 1111 0  0 0  0 0 000 0 0
1 1 012  0 0 000 0 0  0 0 000 0 0  0 0 1  0 0  0 0 000 0 0
// forwarding from port 0, then port 1 with port 0 on another set
1 2 020  1 2 020 abcd 1  0 0 000 0 0  1 abcd 0  1 0  0 0 000 0 0
1 3 030  1 4 040 4444 0  1 3 030 3333 1  1 3333 0  1 1  0 0 000 0 0
1 2 020  0 0 000 0 0  0 0 000 0 0  1 abcd 0  0 0  0 0 000 0 0
// four fills of set 5 go to ways 0 2 1 3, the fifth evicts the first
0 0 000  1 5 050 5000000000000050 1  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
0 0 000  1 5 051 51 0  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
0 0 000  0 0 000 0 0  1 5 052 52 1  0 0 0  0 1  0 0 000 0 0
0 0 000  1 5 053 53 0  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
0 0 000  1 5 054 54 0  0 0 000 0 0  0 0 0  1 0  1 0 050 5000000000000050 1
// read hit of the first line moves the victim to the second
0 0 000  1 6 060 60 0  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
0 0 000  1 6 061 61 1  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
0 0 000  1 6 062 62 0  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
0 0 000  1 6 063 63 0  0 0 000 0 0  0 0 0  1 0  0 0 000 0 0
1 6 060  0 0 000 0 0  0 0 000 0 0  1 60 0  0 0  0 0 000 0 0
0 0 000  1 6 064 64 0  0 0 000 0 0  0 0 0  1 0  1 0 061 61 1
1 6 061  0 0 000 0 0  0 0 000 0 0  0 0 1  0 0  0 0 000 0 0
1 6 064  0 0 000 0 0  0 0 000 0 0  1 64 0  0 0  0 0 000 0 0
// both ports on different sets, fill then write hit
0 0 000  1 7 070 7070 0  1 0 000 0a0a 1  0 0 0  1 1  0 0 000 0 0
0 0 000  1 0 000 0b0b 0  1 7 070 7171 1  0 0 0  0 0  0 0 000 0 0
1 7 070  0 0 000 0 0  0 0 000 0 0  1 7171 0  0 0  0 0 000 0 0
1 0 000  0 0 000 0 0  0 0 000 0 0  1 0b0b 0  0 0  0 0 000 0 0
1 1 011  1 3 030 3030 0  0 0 000 0 0  1 1111 0  0 0  0 0 000 0 0
1 3 030  0 0 000 0 0  0 0 000 0 0  1 3030 0  0 0  0 0 000 0 0
1 4 040  0 0 000 0 0  0 0 000 0 0  1 4444 0  0 0  0 0 000 0 0
// victim on port 1
0 0 000  0 0 000 0 0  1 5 055 55 1  0 0 0  0 1  0 1 051 51 0
0 0 000  0 0 000 0 0  0 0 000 0 0  0 0 0  0 0  0 0 000 0 0

// File: tb/cachemem_tb.sv
// reads up to 64 cases of 23 hex words from tb/cachemem_cases.txt under the project root
`timescale 1ns/1ps
`include "cache_defs.svh"

module cachemem_tb;

  localparam int CASE_WORDS   = 23;
  localparam int MAX_CASES    = 64;
  localparam int MEM_WORDS    = CASE_WORDS * MAX_CASES;
  localparam int RESET_CYCLES = 16;
  localparam int SLACK_CYCLES = 20;
  localparam int LINE_BITS    = `DATA_BITS + `TAG_BITS + 2;

  // word offsets of each group within one case
  localparam int RD  = 0;
  localparam int WR0 = 3;
  localparam int WR1 = 8;
  localparam int EXP = 13;

  localparam string CASE_FILE = "tb/cachemem_cases.txt";

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  rd_en;
  logic [`SET_BITS-1:0]  rd_idx;
  logic [`TAG_BITS-1:0]  rd_tag;
  logic                  wr_en_0;
  logic [`SET_BITS-1:0]  wr_idx_0;
  logic [`TAG_BITS-1:0]  wr_tag_0;
  logic [`DATA_BITS-1:0] wr_data_0;
  logic                  wr_dirty_0;
  logic                  wr_en_1;
  logic [`SET_BITS-1:0]  wr_idx_1;
  logic [`TAG_BITS-1:0]  wr_tag_1;
  logic [`DATA_BITS-1:0] wr_data_1;
  logic                  wr_dirty_1;

  logic [`DATA_BITS-1:0] rd_data;
  logic                  rd_valid;
  logic                  rd_miss_valid;
  logic [`SET_BITS-1:0]  rd_miss_idx;
  logic [`TAG_BITS-1:0]  rd_miss_tag;
  logic                  wr_miss_valid_0;
  logic [`SET_BITS-1:0]  wr_miss_idx_0;
  logic [`TAG_BITS-1:0]  wr_miss_tag_0;
  logic                  wr_miss_valid_1;
  logic [`SET_BITS-1:0]  wr_miss_idx_1;
  logic [`TAG_BITS-1:0]  wr_miss_tag_1;
  logic                  victim_valid_0;
  logic [`SET_BITS-1:0]  victim_idx_0;
  logic [LINE_BITS-1:0]  victim_0;
  logic                  victim_valid_1;
  logic [`SET_BITS-1:0]  victim_idx_1;
  logic [LINE_BITS-1:0]  victim_1;

  logic [63:0] case_mem [MEM_WORDS];
  int          num_cases;
  int          case_num = 0;
  int          errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = MAX_CASES + RESET_CYCLES + SLACK_CYCLES;

  cachemem cachemem_inst (
    .clock           (clock),
    .reset           (reset),
    .rd_en           (rd_en),
    .rd_idx          (rd_idx),
    .rd_tag          (rd_tag),
    .wr_en_0         (wr_en_0),
    .wr_idx_0        (wr_idx_0),
    .wr_tag_0        (wr_tag_0),
    .wr_data_0       (wr_data_0),
    .wr_dirty_0      (wr_dirty_0),
    .wr_en_1         (wr_en_1),
    .wr_idx_1        (wr_idx_1),
    .wr_tag_1        (wr_tag_1),
    .wr_data_1       (wr_data_1),
    .wr_dirty_1      (wr_dirty_1),
    .rd_data         (rd_data),
    .rd_valid        (rd_valid),
    .rd_miss_valid   (rd_miss_valid),
    .rd_miss_idx     (rd_miss_idx),
    .rd_miss_tag     (rd_miss_tag),
    .wr_miss_valid_0 (wr_miss_valid_0),
    .wr_miss_idx_0   (wr_miss_idx_0),
    .wr_miss_tag_0   (wr_miss_tag_0),
    .wr_miss_valid_1 (wr_miss_valid_1),
    .wr_miss_idx_1   (wr_miss_idx_1),
    .wr_miss_tag_1   (wr_miss_tag_1),
    .victim_valid_0  (victim_valid_0),
    .victim_idx_0    (victim_idx_0),
    .victim_0        (victim_0),
    .victim_valid_1  (victim_valid_1),
    .victim_idx_1    (victim_idx_1),
    .victim_1        (victim_1)
  );

  // 100 ns period
  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string field, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0d ns: case %0d %s is %h, expected %h",
               $time, case_num, field, actual, expected);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", field);
    end
  endtask

  // w is the word of the write port group, e the first expected word
  task automatic check_victim(input string name, input logic [LINE_BITS-1:0] line,
                              input logic [`SET_BITS-1:0] idx, input int w, input int e);
    check_value({name, " idx"}, 64'(idx), case_mem[w + 1]);
    check_value({name, " tag"}, 64'(line[`TAG_BITS+1:2]), case_mem[e + 7]);
    check_value({name, " data"}, 64'(line[LINE_BITS-1:`TAG_BITS+2]), case_mem[e + 8]);
    check_value({name, " dirty"}, 64'(line[0]), case_mem[e + 9]);
  endtask

  task automatic apply_case(input int c);
    int b;
    b = c * CASE_WORDS;
    rd_en      = case_mem[b + RD][0];
    rd_idx     = case_mem[b + RD + 1][`SET_BITS-1:0];
    rd_tag     = case_mem[b + RD + 2][`TAG_BITS-1:0];
    wr_en_0    = case_mem[b + WR0][0];
    wr_idx_0   = case_mem[b + WR0 + 1][`SET_BITS-1:0];
    wr_tag_0   = case_mem[b + WR0 + 2][`TAG_BITS-1:0];
    wr_data_0  = case_mem[b + WR0 + 3];
    wr_dirty_0 = case_mem[b + WR0 + 4][0];
    wr_en_1    = case_mem[b + WR1][0];
    wr_idx_1   = case_mem[b + WR1 + 1][`SET_BITS-1:0];
    wr_tag_1   = case_mem[b + WR1 + 2][`TAG_BITS-1:0];
    wr_data_1  = case_mem[b + WR1 + 3];
    wr_dirty_1 = case_mem[b + WR1 + 4][0];
  endtask

  task automatic check_case(input int c);
    int b;
    int e;
    b = c * CASE_WORDS;
    e = b + EXP;
    check_value("rd_valid", 64'(rd_valid), case_mem[e]);
    if (case_mem[e][0]) begin
      check_value("rd_data", rd_data, case_mem[e + 1]);
    end
    check_value("rd_miss_valid", 64'(rd_miss_valid), case_mem[e + 2]);
    // a miss carries the request address
    if (case_mem[e + 2][0]) begin
      check_value("rd_miss_idx", 64'(rd_miss_idx), case_mem[b + RD + 1]);
      check_value("rd_miss_tag", 64'(rd_miss_tag), case_mem[b + RD + 2]);
    end
    check_value("wr_miss_valid_0", 64'(wr_miss_valid_0), case_mem[e + 3]);
    if (case_mem[e + 3][0]) begin
      check_value("wr_miss_idx_0", 64'(wr_miss_idx_0), case_mem[b + WR0 + 1]);
      check_value("wr_miss_tag_0", 64'(wr_miss_tag_0), case_mem[b + WR0 + 2]);
    end
    check_value("wr_miss_valid_1", 64'(wr_miss_valid_1), case_mem[e + 4]);
    if (case_mem[e + 4][0]) begin
      check_value("wr_miss_idx_1", 64'(wr_miss_idx_1), case_mem[b + WR1 + 1]);
      check_value("wr_miss_tag_1", 64'(wr_miss_tag_1), case_mem[b + WR1 + 2]);
    end
    check_value("victim_valid_0", 64'(victim_valid_0), case_mem[e + 5]);
    if (case_mem[e + 5][0]) begin
      check_victim("victim_0", victim_0, victim_idx_0, b + WR0, e);
    end
    check_value("victim_valid_1", 64'(victim_valid_1), case_mem[e + 6]);
    if (case_mem[e + 6][0]) begin
      check_victim("victim_1", victim_1, victim_idx_1, b + WR1, e);
    end
  endtask

  // drive 10 ns after the edge, sample 10 ns before the next one
  task automatic run_cases();
    repeat (RESET_CYCLES) @(posedge clock);
    #10;
    reset = 1'b0;
    for (int c = 0; c < num_cases; c++) begin
      case_num = c;
      apply_case(c);
      #80;
      check_case(c);
      @(posedge clock);
      #10;
    end
  endtask

  initial begin
    reset      = 1'b1;
    rd_en      = 1'b0;
    rd_idx     = '0;
    rd_tag     = '0;
    wr_en_0    = 1'b0;
    wr_idx_0   = '0;
    wr_tag_0   = '0;
    wr_data_0  = '0;
    wr_dirty_0 = 1'b0;
    wr_en_1    = 1'b0;
    wr_idx_1   = '0;
    wr_tag_1   = '0;
    wr_data_1  = '0;
    wr_dirty_1 = 1'b0;
    // words past the file keep a value no rd_en word can have
    for (int i = 0; i < MEM_WORDS; i++) begin
      case_mem[i] = ~64'(i);
    end
    $readmemh(CASE_FILE, case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[num_cases * CASE_WORDS] <= 64'd1) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("No cases could be read from %s", CASE_FILE);
      $display("Finished with errors");
      $fatal(1, "empty case file");
    end else begin
      cycle_limit = num_cases + RESET_CYCLES + SLACK_CYCLES;
      run_cases();
      if (errors == 0) begin
        $display("Finished with no errors");
        $finish;
      end else begin
        $display("Finished with errors");
        $fatal(1, "%0d checks failed", errors);
      end
    end
  end

endmodule

// File: vlog.f
+incdir+design
design/cache_pkg.sv
design/way_lookup.sv
design/plru_tree.sv
design/cachemem.sv
tb/cachemem_tb.sv
